// File: design/frv_fetch_pkg.sv
`default_nettype none

/*
 Fetch front end sizing constants.
 Control flow targets and the reset PC must be 4-byte aligned.
 The buffer holds BUF_HALFWORDS halfwords and needs 2 free for a load.
*/

package frv_fetch_pkg;

    // ----------------------------------------
    // Bus and address widths
    // ----------------------------------------
    localparam int XLEN = 32;                              // Address and data word width

    localparam logic [XLEN-1:0] PC_RESET_VALUE = 32'h8000_0000; // First fetch address

    // ----------------------------------------
    // Buffer and outstanding depth
    // ----------------------------------------
    localparam int BUF_HALFWORDS = 4;                      // Halfword slots in fetch buffer

    localparam int OUTST_W = 2;                            // Outstanding and ignore counters

    localparam logic [OUTST_W-1:0] MAX_OUTSTANDING = 2'd2; // Granted but not yet received

endpackage

`default_nettype wire

// File: design/frv_isa_pkg.sv
`default_nettype none

/*
 Instruction word views and length encoding.
 Only the 16/32-bit length rule is decoded here.
 Longer RISC-V encodings are not supported.
*/

package frv_isa_pkg;

    localparam int ILEN = 32;                  // Full instruction width
    localparam int HLEN = 16;                  // Halfword width

    // Low two bits of first halfword for a 32-bit instruction
    localparam logic [1:0] ILEN32_CODE = 2'b11;

    // Two halfwords in memory order
    typedef struct packed {
        logic [HLEN-1:0] hi;                   // Upper halfword, higher address
        logic [HLEN-1:0] lo;                   // Lower halfword, holds length bits
    } instr_halves_t;

    // Same word seen whole or split
    typedef union packed {
        logic [ILEN-1:0] full;                 // Complete 32-bit instruction
        instr_halves_t   half;                 // Halfword view for length decode
    } instr_word_t;

endpackage

`default_nettype wire

// File: design/frv_pipeline_fetch.sv
`timescale 1ns/1ps
`default_nettype none

/*
 Fetch address generation and instruction bus control.
 Reads are word aligned; at most MAX_OUTSTANDING responses in flight.
 Responses issued before a control flow change are dropped.
*/

module frv_pipeline_fetch (
    input  wire                              g_clk,       // Core clock
    input  wire                              g_resetn,    // Sync reset, active low

    input  wire                              cf_req,      // Control flow change
    input  wire  [frv_fetch_pkg::XLEN-1:0]   cf_target,   // New fetch address
    output logic                             cf_ack,      // Change accepted

    output logic                             imem_req,    // Read request
    output logic [frv_fetch_pkg::XLEN-1:0]   imem_addr,   // Read address
    input  wire                              imem_gnt,    // Request granted
    output logic                             imem_ack,    // Response taken
    input  wire                              imem_recv,   // Response present
    input  wire                              imem_error,  // Response error
    input  wire  [frv_fetch_pkg::XLEN-1:0]   imem_rdata,  // Response data

    input  wire                              f_ready,     // Buffer has 2 free halfwords
    output logic                             f_load,      // Load word into buffer
    output logic                             f_err,       // Error flag of loaded word
    output logic [frv_fetch_pkg::XLEN-1:0]   f_word       // Loaded word
);

    logic                                req_fire;       // Request granted this cycle
    logic                                rsp_recv;       // Response accepted this cycle
    logic                                cf_change;      // Control flow change taken
    logic                                drop_rsp;       // Responses from old path pending
    logic                                n_imem_req;     // Next request flag
    logic [frv_fetch_pkg::OUTST_W-1:0]   gnt_inc;        // Grant as counter increment
    logic [frv_fetch_pkg::OUTST_W-1:0]   rsp_dec;        // Receive as counter decrement
    logic [frv_fetch_pkg::OUTST_W-1:0]   outst_q;        // Granted, not yet received
    logic [frv_fetch_pkg::OUTST_W-1:0]   outst_n;
    logic [frv_fetch_pkg::OUTST_W-1:0]   ignore_q;       // Responses still to drop

    // ----------------------------------------
    // Handshakes
    // ----------------------------------------
    assign req_fire  = imem_req && imem_gnt;
    assign imem_ack  = f_ready;                           // Memory holds until buffer room
    assign rsp_recv  = imem_recv && imem_ack;
    assign cf_ack    = !imem_req || imem_gnt;             // No request left waiting
    assign cf_change = cf_req && cf_ack;

    assign gnt_inc = {{(frv_fetch_pkg::OUTST_W-1){1'b0}}, req_fire};
    assign rsp_dec = {{(frv_fetch_pkg::OUTST_W-1){1'b0}}, rsp_recv};
    assign outst_n = outst_q + gnt_inc - rsp_dec;

    // Waiting request holds, new one only with a free outstanding slot
    assign n_imem_req = (imem_req && !imem_gnt) ||
                        ((f_ready || cf_change) && (outst_n < frv_fetch_pkg::MAX_OUTSTANDING));

    // ----------------------------------------
    // Request address and flag
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_addr <= frv_fetch_pkg::PC_RESET_VALUE;
        end else if (cf_change) begin
            imem_addr <= cf_target;                       // Redirect wins over advance
        end else if (req_fire) begin
            imem_addr <= imem_addr + 'd4;                 // Next word
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_req <= 1'b0;
        end else begin
            imem_req <= n_imem_req;
        end
    end

    // ----------------------------------------
    // Outstanding and dropped responses
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            outst_q <= '0;
        end else begin
            outst_q <= outst_n;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ignore_q <= '0;
        end else if (cf_change) begin
            ignore_q <= outst_n;                          // All in flight are old path
        end else if (drop_rsp) begin
            ignore_q <= ignore_q - rsp_dec;
        end
    end

    assign drop_rsp = |ignore_q;

    // Response straight to buffer, same edge
    assign f_load = rsp_recv && !drop_rsp;
    assign f_err  = imem_error;
    assign f_word = imem_rdata;

    // ----------------------------------------
    // Assertions
    // ----------------------------------------
    a_outst_max : assert property (@(posedge g_clk) disable iff (!g_resetn)
        outst_q <= frv_fetch_pkg::MAX_OUTSTANDING)
        else $error("outstanding count above limit");

    a_addr_hold : assert property (@(posedge g_clk) disable iff (!g_resetn)
        imem_req && !imem_gnt |=> $stable(imem_addr))
        else $error("imem_addr changed while waiting for grant");

endmodule

`default_nettype wire

// File: design/frv_fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

/*
 Halfword buffer between instruction bus and decode.
 Valid slots are packed from slot 0; a load appends two halfwords.
 Loads arrive only with at least two free slots.
*/

module frv_fetch_buffer (
    input  wire                              g_clk,       // Core clock
    input  wire                              g_resetn,    // Sync reset, active low

    input  wire                              flush,       // Drop all contents
    input  wire                              f_load,      // Append word
    input  wire                              f_err,       // Word came with bus error
    input  wire  [frv_fetch_pkg::XLEN-1:0]   f_word,      // Word, low halfword first
    output logic                             f_ready,     // Two slots free

    input  wire                              buf_ready,   // Decode takes head
    output logic                             buf_valid,   // Head instruction complete
    output logic [frv_fetch_pkg::XLEN-1:0]   buf_out,     // Head instruction
    output logic                             buf_len32,   // Head is 32-bit
    output logic                             buf_err      // Head has error halfword
);

    logic [frv_fetch_pkg::BUF_HALFWORDS-1:0][frv_isa_pkg::HLEN-1:0] hw_q;  // Slot data
    logic [frv_fetch_pkg::BUF_HALFWORDS-1:0][frv_isa_pkg::HLEN-1:0] hw_n;
    logic [frv_fetch_pkg::BUF_HALFWORDS-1:0]                        vld_q; // Slot valid
    logic [frv_fetch_pkg::BUF_HALFWORDS-1:0]                        vld_n;
    logic [frv_fetch_pkg::BUF_HALFWORDS-1:0]                        err_q; // Slot error
    logic [frv_fetch_pkg::BUF_HALFWORDS-1:0]                        err_n;

    frv_isa_pkg::instr_word_t head;                      // Slots 0 and 1 as one word
    logic                     pop;                       // Head consumed this cycle
    int                       pop_n;                     // Slots removed
    int                       fill;                      // First free slot after pop

    // ----------------------------------------
    // Head decode
    // ----------------------------------------
    assign head.half.lo = hw_q[0];
    assign head.half.hi = hw_q[1];

    assign buf_len32 = head.half.lo[1:0] == frv_isa_pkg::ILEN32_CODE;
    assign buf_out   = head.full;                        // Upper half unused for 16-bit
    assign buf_valid = vld_q[0] && (!buf_len32 || vld_q[1]);
    assign buf_err   = err_q[0] || (buf_len32 && err_q[1]);

    // Thermometer valid, so slot 2 empty means two free
    assign f_ready = !vld_q[frv_fetch_pkg::BUF_HALFWORDS-2];

    assign pop   = buf_ready && buf_valid;
    assign pop_n = !pop ? 0 : (buf_len32 ? 2 : 1);

    // ----------------------------------------
    // Shift out and append
    // ----------------------------------------
    always_comb begin
        hw_n  = hw_q;
        vld_n = '0;
        err_n = '0;
        fill  = 0;
        for (int i = 0; i < frv_fetch_pkg::BUF_HALFWORDS; i++) begin
            if (i + pop_n < frv_fetch_pkg::BUF_HALFWORDS) begin
                hw_n[i]  = hw_q[i + pop_n];
                vld_n[i] = vld_q[i + pop_n];
                err_n[i] = err_q[i + pop_n];
            end
            if (vld_n[i]) begin
                fill = i + 1;                            // Count survivors
            end
        end
        for (int i = 0; i < frv_fetch_pkg::BUF_HALFWORDS; i++) begin
            if (f_load && i == fill) begin
                hw_n[i]  = f_word[frv_isa_pkg::HLEN-1:0];        // Lower address
                vld_n[i] = 1'b1;
                err_n[i] = f_err;
            end else if (f_load && i == fill + 1) begin
                hw_n[i]  = f_word[frv_fetch_pkg::XLEN-1:frv_isa_pkg::HLEN];
                vld_n[i] = 1'b1;
                err_n[i] = f_err;
            end
        end
    end

    // ----------------------------------------
    // State
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            vld_q <= '0;
        end else if (flush) begin
            vld_q <= '0;                                 // Same-cycle load is old path
        end else begin
            vld_q <= vld_n;
        end
    end

    always_ff @(posedge g_clk) begin
        hw_q  <= hw_n;
        err_q <= err_n;                                  // Qualified by vld_q
    end

    // Fetch side must respect buffer room
    a_load_room : assert property (@(posedge g_clk) disable iff (!g_resetn)
        f_load |-> f_ready)
        else $error("buffer load without two free halfwords");

endmodule

`default_nettype wire

// File: design/frv_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

/*
 Fetch front end top level.
 Environment must raise fe_flush on the cycle a control flow change is acked.
*/

module frv_fetch_top (
    input  wire                              g_clk,       // Core clock
    input  wire                              g_resetn,    // Sync reset, active low

    input  wire                              cf_req,      // Control flow change
    input  wire  [frv_fetch_pkg::XLEN-1:0]   cf_target,   // Aligned target
    output wire                              cf_ack,      // Change accepted

    output wire                              imem_req,    // Instruction read request
    output wire  [frv_fetch_pkg::XLEN-1:0]   imem_addr,   // Word address
    input  wire                              imem_gnt,    // Request granted
    input  wire                              imem_recv,   // Response present
    output wire                              imem_ack,    // Response taken
    input  wire                              imem_error,  // Response error
    input  wire  [frv_fetch_pkg::XLEN-1:0]   imem_rdata,  // Response data

    input  wire                              fe_flush,    // Empty buffer
    input  wire                              fe_stall,    // Hold decode output
    output wire                              fe_ready,    // Instruction offered

    output wire  [frv_fetch_pkg::XLEN-1:0]   d_data,      // Instruction to decode
    output wire                              d_len32,     // 32-bit instruction
    output wire                              d_error      // Fetch error on instruction
);

    wire                             f_ready;             // Buffer room for one word
    wire                             f_load;              // Word into buffer
    wire                             f_err;
    wire [frv_fetch_pkg::XLEN-1:0]   f_word;
    wire                             buf_ready = fe_ready && !fe_stall; // Decode consumes

    frv_pipeline_fetch frv_pipeline_fetch_inst (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .cf_req     (cf_req),
        .cf_target  (cf_target),
        .cf_ack     (cf_ack),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_gnt   (imem_gnt),
        .imem_ack   (imem_ack),
        .imem_recv  (imem_recv),
        .imem_error (imem_error),
        .imem_rdata (imem_rdata),
        .f_ready    (f_ready),
        .f_load     (f_load),
        .f_err      (f_err),
        .f_word     (f_word)
    );

    frv_fetch_buffer frv_fetch_buffer_inst (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .flush      (fe_flush),
        .f_load     (f_load),
        .f_err      (f_err),
        .f_word     (f_word),
        .f_ready    (f_ready),
        .buf_ready  (buf_ready),
        .buf_valid  (fe_ready),                              // Offer while complete
        .buf_out    (d_data),
        .buf_len32  (d_len32),
        .buf_err    (d_error)
    );

endmodule

`default_nettype wire

// File: sim/tb_fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

/*
 Watches the fetch top ports and compares consumed instructions with memory.
 Consumes during fe_flush are old path and not compared.
*/

module tb_fetch_checker (
    input wire                             g_clk,
    input wire                             g_resetn,
    input wire                             cf_req,
    input wire [frv_fetch_pkg::XLEN-1:0]   cf_target,
    input wire                             cf_ack,
    input wire                             imem_req,
    input wire [frv_fetch_pkg::XLEN-1:0]   imem_addr,
    input wire                             imem_gnt,
    input wire                             imem_ack,
    input wire                             fe_flush,
    input wire                             fe_stall,
    input wire                             fe_ready,
    input wire [frv_fetch_pkg::XLEN-1:0]   d_data,
    input wire                             d_len32,
    input wire                             d_error
);

    int                              err_count = 0;
    int                              chk_count = 0;
    logic [31:0]                     exp_pc    = frv_fetch_pkg::PC_RESET_VALUE;
    logic                            seen_req  = 1'b0;   // First request checked
    logic                            seen_cf   = 1'b0;
    logic                            held      = 1'b0;   // Stalled offer last cycle
    logic                            may_req   = 1'b1;   // Request allowed this cycle
    logic [31:0]                     held_data = '0;
    logic                            held_len  = 1'b0;
    logic                            held_err  = 1'b0;
    frv_isa_pkg::instr_word_t        exp_w;
    logic                            exp_len;
    logic                            exp_err;

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        h[1:0]   = h[20] ? 2'b11 : h[1:0];
        h[17:16] = h[4] ? 2'b11 : h[17:16];
        return h;
    endfunction

    function automatic logic [15:0] halfword_at(input logic [31:0] a);
        logic [31:0] w;
        w = mem_word({a[31:2], 2'b00});
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    // Reference instruction at a halfword address with upper half zero if compressed
    function automatic frv_isa_pkg::instr_word_t expect_instr(input logic [31:0] pc);
        frv_isa_pkg::instr_word_t w;
        w.half.lo = halfword_at(pc);
        w.half.hi = (w.half.lo[1:0] == frv_isa_pkg::ILEN32_CODE) ? halfword_at(pc + 2) : '0;
        return w;
    endfunction

    function automatic logic expect_err(input logic [31:0] pc, input logic len32);
        logic e0;
        logic e1;
        e0 = (pc >= 32'h8000_0040) && (pc < 32'h8000_0080);
        e1 = (pc + 2 >= 32'h8000_0040) && (pc + 2 < 32'h8000_0080);
        return e0 || (len32 && e1);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        err_count++;
        $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
    endtask

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            chk_count++;
            if (imem_req)  report_mismatch("imem_req", 32'h0, 32'h1);
            if (fe_ready)  report_mismatch("fe_ready", 32'h0, 32'h1);
            if (!cf_ack)   report_mismatch("cf_ack", 32'h1, 32'h0);
            exp_pc = frv_fetch_pkg::PC_RESET_VALUE;
            held   = 1'b0;
        end else begin
            if (imem_req && !seen_req) begin
                seen_req = 1'b1;
                if (!seen_cf && imem_addr !== frv_fetch_pkg::PC_RESET_VALUE) begin
                    report_mismatch("imem_addr", frv_fetch_pkg::PC_RESET_VALUE, imem_addr);
                end
            end
            if (!may_req && imem_req) begin
                err_count++;
                $display("Request raised while the buffer had no room at %0t", $time);
            end
            if (!fe_ready) begin                         // At most one halfword held
                chk_count++;
                if (imem_ack !== 1'b1) report_mismatch("imem_ack", 32'h1, 32'(imem_ack));
            end
            if (held && !fe_flush) begin                 // Stalled head must hold
                chk_count++;
                if (!fe_ready) report_mismatch("fe_ready", 32'h1, 32'h0);
                if (d_len32 !== held_len)
                    report_mismatch("d_len32", 32'(held_len), 32'(d_len32));
                if (d_error !== held_err)
                    report_mismatch("d_error", 32'(held_err), 32'(d_error));
                if (held_len ? d_data !== held_data : d_data[15:0] !== held_data[15:0])
                    report_mismatch("d_data", held_data, d_data);
            end
            if (cf_req && cf_ack) begin
                exp_pc  = cf_target;                     // New path starts here
                seen_cf = 1'b1;
            end else if (fe_ready && !fe_stall && !fe_flush) begin
                exp_w   = expect_instr(exp_pc);
                exp_len = exp_w.half.lo[1:0] == frv_isa_pkg::ILEN32_CODE;
                exp_err = expect_err(exp_pc, exp_len);
                chk_count++;
                if (d_len32 !== exp_len)
                    report_mismatch("d_len32", 32'(exp_len), 32'(d_len32));
                if (d_error !== exp_err)
                    report_mismatch("d_error", 32'(exp_err), 32'(d_error));
                if (exp_len ? d_data !== exp_w.full : d_data[15:0] !== exp_w.half.lo)
                    report_mismatch("d_data", exp_w.full, d_data);
                exp_pc = exp_pc + (exp_len ? 32'd4 : 32'd2);
            end
            held      = fe_ready && fe_stall && !fe_flush;
            held_data = d_data;
            held_len  = d_len32;
            held_err  = d_error;
            may_req   = imem_ack || (cf_req && cf_ack) || (imem_req && !imem_gnt);
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

/*
 Testbench top for the fetch front end.
 Memory model answers in order with 0..3 cycle grant and receive delays.
 Control flow targets stay 4-byte aligned in the low 256 bytes of the region.
*/

module tb_fetch_top;

    localparam int N_CONSUMES     = 400;               // Instructions to consume
    localparam int TIMEOUT_CYCLES = N_CONSUMES * 20;   // Watchdog budget
    localparam int CLK_PERIOD     = 4;

    logic                              g_clk      = 1'b0;
    logic                              g_resetn   = 1'b0;
    logic                              cf_req     = 1'b0;
    logic [frv_fetch_pkg::XLEN-1:0]    cf_target  = '0;
    logic                              imem_gnt   = 1'b0;
    logic                              imem_recv  = 1'b0;
    logic                              imem_error = 1'b0;
    logic [frv_fetch_pkg::XLEN-1:0]    imem_rdata = '0;
    logic                              fe_flush   = 1'b0;
    logic                              fe_stall   = 1'b0;
    wire                               cf_ack;
    wire                               imem_req;
    wire  [frv_fetch_pkg::XLEN-1:0]    imem_addr;
    wire                               imem_ack;
    wire                               fe_ready;
    wire  [frv_fetch_pkg::XLEN-1:0]    d_data;
    wire                               d_len32;
    wire                               d_error;

    logic [frv_fetch_pkg::XLEN-1:0]    pend_q[$];      // Granted addresses, oldest first
    int                                gnt_wait  = 0;
    int                                rsp_wait  = 0;
    logic                              rsp_busy  = 1'b0;
    int                                consumed  = 0;

    // Same hash as the checker's reference model
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        h[1:0]   = h[20] ? 2'b11 : h[1:0];             // Bias toward 32-bit
        h[17:16] = h[4] ? 2'b11 : h[17:16];
        return h;
    endfunction

    function automatic logic in_err_region(input logic [31:0] a);
        return (a >= 32'h8000_0040) && (a < 32'h8000_0080);
    endfunction

    frv_fetch_top frv_fetch_top_inst (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .cf_req (cf_req), .cf_target (cf_target), .cf_ack (cf_ack),
        .imem_req (imem_req), .imem_addr (imem_addr), .imem_gnt (imem_gnt),
        .imem_recv (imem_recv), .imem_ack (imem_ack), .imem_error (imem_error),
        .imem_rdata (imem_rdata),
        .fe_flush (fe_flush), .fe_stall (fe_stall), .fe_ready (fe_ready),
        .d_data (d_data), .d_len32 (d_len32), .d_error (d_error)
    );

    tb_fetch_checker checker_inst (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .cf_req (cf_req), .cf_target (cf_target), .cf_ack (cf_ack),
        .imem_req (imem_req), .imem_addr (imem_addr), .imem_gnt (imem_gnt),
        .imem_ack (imem_ack), .fe_flush (fe_flush), .fe_stall (fe_stall),
        .fe_ready (fe_ready), .d_data (d_data), .d_len32 (d_len32), .d_error (d_error)
    );

    // ----------------------------------------
    // Clock, reset, watchdog
    // ----------------------------------------
    initial begin
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all instructions were consumed");
        $display("TB FAILED");
        $finish;
    end

    // ----------------------------------------
    // Memory model
    // ----------------------------------------
    always @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_gnt  <= 1'b0;
            imem_recv <= 1'b0;
            rsp_busy  = 1'b0;
            pend_q.delete();
        end else begin
            if (imem_req && imem_gnt) begin
                pend_q.push_back(imem_addr);             // Accepted at this edge
                imem_gnt <= 1'b0;
                gnt_wait = $urandom % 4;
            end else if (imem_req) begin
                if (gnt_wait == 0) imem_gnt <= 1'b1;
                else gnt_wait = gnt_wait - 1;
            end
            if (rsp_busy && imem_recv && imem_ack) begin
                imem_recv <= 1'b0;                       // Delay before next response
                rsp_busy  = 1'b0;
                rsp_wait  = $urandom % 4;
            end else if (!rsp_busy && pend_q.size() > 0) begin
                if (rsp_wait == 0) begin
                    imem_recv  <= 1'b1;
                    imem_rdata <= mem_word(pend_q[0]);
                    imem_error <= in_err_region(pend_q[0]);
                    void'(pend_q.pop_front());
                    rsp_busy = 1'b1;
                end else begin
                    rsp_wait = rsp_wait - 1;
                end
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        void'($urandom(32'h7fb6));
        repeat (4) @(posedge g_clk);
        g_resetn <= 1'b1;
        while (consumed < N_CONSUMES) begin
            @(posedge g_clk);
            if (g_resetn && fe_ready && !fe_stall && !fe_flush) consumed++;
            fe_stall <= ($urandom % 4) == 0;
            if (cf_req && cf_ack) begin
                cf_req   <= 1'b0;                        // Flush ends with the accepted change
                fe_flush <= 1'b0;
            end else if (!cf_req && ($urandom % 40) == 0) begin
                cf_req    <= 1'b1;
                fe_flush  <= 1'b1;                       // Held until acked
                cf_target <= 32'h8000_0000 | (($urandom % 64) << 2);
            end
        end
        repeat (4) @(posedge g_clk);
        $display("errors=%0d checks=%0d consumed=%0d",
                 checker_inst.err_count, checker_inst.chk_count, consumed);
        if (checker_inst.err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
design/frv_fetch_pkg.sv
design/frv_isa_pkg.sv
design/frv_pipeline_fetch.sv
design/frv_fetch_buffer.sv
design/frv_fetch_top.sv
sim/tb_fetch_checker.sv
sim/tb_fetch_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; fails if the log reports a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f list.f \
    --top-module tb_fetch_top -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
